// ==== common/cache_pkg.sv ====
// cache geometry, address field types, tag entry, line and cpu request structs
package cache_pkg;

    localparam int ADDR_WIDTH     = 32;
    localparam int WORD_WIDTH     = 32;
    localparam int LINE_WORDS     = 4;
    localparam int WAYS           = 4;
    localparam int SETS           = 64;

    localparam int BYTES_PER_WORD = WORD_WIDTH / 8;
    localparam int OFFSET_WIDTH   = $clog2(LINE_WORDS * BYTES_PER_WORD); // 4
    localparam int INDEX_WIDTH    = $clog2(SETS);                        // 6
    localparam int TAG_WIDTH      = ADDR_WIDTH - INDEX_WIDTH - OFFSET_WIDTH; // 22
    localparam int WORD_SEL_WIDTH = $clog2(LINE_WORDS); // word within a line
    localparam int WAY_WIDTH      = $clog2(WAYS);

    typedef logic [WORD_WIDTH-1:0]   word_t;
    typedef logic [ADDR_WIDTH-1:0]   addr_t;
    typedef logic [TAG_WIDTH-1:0]    tag_t;
    typedef logic [INDEX_WIDTH-1:0]  index_t;
    typedef logic [OFFSET_WIDTH-1:0] offset_t;
    typedef logic [WAY_WIDTH-1:0]    way_t;
    typedef logic [WAYS-1:0]         way_mask_t; // hit vector, write enables

    // one entry per way and set
    typedef struct packed {
        logic valid;
        tag_t tag;
    } tagv_t;

    typedef logic [LINE_WORDS-1:0][WORD_WIDTH-1:0] line_t; // word 0 in the low bits

    typedef struct packed {
        logic  valid;
        addr_t addr;
        logic  cached;
    } cpu_req_t;

    // request held between lookup and miss control
    typedef struct packed {
        logic    valid;
        tag_t    tag;
        index_t  index;
        offset_t offset;
        logic    cached;
    } req_buf_t;

endpackage

// ==== common/mem_bus_pkg.sv ====
// memory-side read request and response structs and burst kinds
package mem_bus_pkg;

    localparam int MEM_ADDR_WIDTH = 32;
    localparam int MEM_DATA_WIDTH = 32;

    typedef enum logic {
        BURST_WORD, // one beat
        BURST_LINE  // a whole cache line, word 0 first
    } burst_t;

    // rd_req held until rd_rdy is sampled high
    typedef struct packed {
        logic                      rd_req;
        logic [MEM_ADDR_WIDTH-1:0] addr;
        burst_t                    burst;
    } mem_req_t;

    typedef struct packed {
        logic                      rd_rdy;
        logic                      ret_valid;
        logic                      ret_last;  // final beat of the burst
        logic [MEM_DATA_WIDTH-1:0] ret_data;
    } mem_resp_t;

endpackage

// ==== icache/icache_lookup.sv ====
// lookup stage: request buffer, acceptance, flush and ram read index
`timescale 1ns/1ps

module icache_lookup (
    input  logic                clk,
    input  logic                reset,
    input  cache_pkg::cpu_req_t cpu_req,
    input  logic                stall,
    input  logic                flush,
    input  logic                hold,
    input  logic                replay,
    input  cache_pkg::index_t   replay_index,
    output logic                busy,
    output cache_pkg::req_buf_t req_buf,
    output cache_pkg::index_t   ram_index,
    output logic                ram_read_en
);

    import cache_pkg::*;

    tag_t    in_tag;
    index_t  in_index;
    offset_t in_offset;

    logic    load;
    logic    valid_q;
    tag_t    tag_q;
    index_t  index_q;
    offset_t offset_q;
    logic    cached_q;

    assign in_tag    = cpu_req.addr[ADDR_WIDTH-1 -: TAG_WIDTH];
    assign in_index  = cpu_req.addr[OFFSET_WIDTH +: INDEX_WIDTH];
    assign in_offset = cpu_req.addr[OFFSET_WIDTH-1:0];

    assign busy = hold;
    assign load = !hold && !stall; // buffer takes whatever the cpu presents

    // flush drops the held request, and any request offered with it
    always_ff @(posedge clk) begin
        if (reset || flush) begin
            valid_q <= 1'b0;
        end else if (load) begin
            valid_q <= cpu_req.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            tag_q    <= in_tag;
            index_q  <= in_index;
            offset_q <= in_offset;
            cached_q <= cpu_req.cached;
        end
    end

    // flushed request gives no response in its own cycle either
    assign req_buf = '{
        valid:  valid_q && !flush,
        tag:    tag_q,
        index:  index_q,
        offset: offset_q,
        cached: cached_q
    };

    // while nothing new is taken the same set is read again, outputs stay put
    assign ram_index   = replay ? replay_index : (load ? in_index : index_q);
    assign ram_read_en = load || replay;

endmodule

// ==== icache/icache_miss_ctrl.sv ====
// miss control stage: tag compare, word select, refill and uncached fsm
`timescale 1ns/1ps

module icache_miss_ctrl (
    input  logic                                     clk,
    input  logic                                     reset,
    input  cache_pkg::req_buf_t                      req_buf,
    input  cache_pkg::tagv_t [cache_pkg::WAYS-1:0]   tagv_rdata,
    input  cache_pkg::line_t [cache_pkg::WAYS-1:0]   line_rdata,
    input  cache_pkg::way_t                          victim,
    input  logic                                     stall,
    input  mem_bus_pkg::mem_resp_t                   mem_resp,
    output logic                                     hold,
    output logic                                     replay,
    output cache_pkg::index_t                        replay_index,
    output cache_pkg::way_mask_t                     tag_we,
    output cache_pkg::way_mask_t                     data_we,
    output cache_pkg::tagv_t                         tagv_wdata,
    output cache_pkg::line_t                         line_wdata,
    output logic                                     plru_update,
    output cache_pkg::way_t                          plru_way,
    output cache_pkg::index_t                        plru_index,
    output mem_bus_pkg::mem_req_t                    mem_req,
    output logic                                     rdata_valid,
    output cache_pkg::word_t                         rdata
);

    import cache_pkg::*;
    import mem_bus_pkg::*;

    typedef enum logic [2:0] {
        S_LOOKUP,
        S_LINE_REQ,
        S_LINE_RECV,
        S_FILL,
        S_REPLAY,
        S_WORD_REQ,
        S_WORD_WAIT,
        S_WORD_DONE
    } state_t;

    state_t                    state_q;
    state_t                    state_d;
    way_mask_t                 hit;
    way_t                      hit_way;
    word_t                     hit_word;
    logic                      cache_hit;
    logic                      lookup_hit;
    logic [WORD_SEL_WIDTH-1:0] word_sel;
    logic [WORD_SEL_WIDTH-1:0] beat_q;
    line_t                     line_q;
    word_t                     uncached_q;

    assign word_sel = req_buf.offset[OFFSET_WIDTH-1 -: WORD_SEL_WIDTH];

    always_comb begin
        hit      = '0;
        hit_way  = '0;
        hit_word = '0;
        for (int w = 0; w < WAYS; w++) begin
            if (tagv_rdata[w].valid && tagv_rdata[w].tag == req_buf.tag) begin
                hit[w]   = 1'b1;
                hit_way  = way_t'(w);
                hit_word = line_rdata[w][word_sel];
            end
        end
    end

    assign cache_hit  = |hit;
    assign lookup_hit = state_q == S_LOOKUP && req_buf.valid && req_buf.cached && cache_hit;

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q <= S_LOOKUP;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            S_LOOKUP: begin
                if (req_buf.valid && !req_buf.cached) begin
                    state_d = S_WORD_REQ;
                end else if (req_buf.valid && !cache_hit) begin
                    state_d = S_LINE_REQ;
                end
            end
            S_LINE_REQ:  if (mem_resp.rd_rdy) state_d = S_LINE_RECV;
            S_LINE_RECV: if (mem_resp.ret_valid && mem_resp.ret_last) state_d = S_FILL;
            S_FILL:      state_d = S_REPLAY;
            S_REPLAY:    state_d = S_LOOKUP; // ram now reads the new line
            S_WORD_REQ:  if (mem_resp.rd_rdy) state_d = S_WORD_WAIT;
            S_WORD_WAIT: if (mem_resp.ret_valid) state_d = S_WORD_DONE;
            S_WORD_DONE: if (!stall) state_d = S_LOOKUP;
            default:     state_d = S_LOOKUP;
        endcase
    end

    // beat k of a line burst is word k
    always_ff @(posedge clk) begin
        if (reset) begin
            beat_q <= '0;
        end else if (state_q == S_LINE_REQ) begin
            beat_q <= '0;
        end else if (state_q == S_LINE_RECV && mem_resp.ret_valid) begin
            beat_q <= beat_q + WORD_SEL_WIDTH'(1);
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == S_LINE_RECV && mem_resp.ret_valid) begin
            line_q[beat_q] <= mem_resp.ret_data;
        end
        if (state_q == S_WORD_WAIT && mem_resp.ret_valid) begin
            uncached_q <= mem_resp.ret_data;
        end
    end

    // busy drops on a hit and while the uncached word is handed back
    assign hold = (state_q == S_LOOKUP)
                ? (req_buf.valid && (!req_buf.cached || !cache_hit))
                : (state_q != S_WORD_DONE);

    assign replay       = state_q == S_REPLAY;
    assign replay_index = req_buf.index;

    assign tag_we     = (state_q == S_FILL) ? way_mask_t'(1) << victim : '0;
    assign data_we    = tag_we;
    assign tagv_wdata = '{valid: 1'b1, tag: req_buf.tag};
    assign line_wdata = line_q;

    assign plru_update = lookup_hit || state_q == S_FILL;
    assign plru_way    = (state_q == S_FILL) ? victim : hit_way;
    assign plru_index  = req_buf.index;

    always_comb begin
        mem_req.rd_req = state_q == S_LINE_REQ || state_q == S_WORD_REQ;
        mem_req.burst  = (state_q == S_LINE_REQ) ? BURST_LINE : BURST_WORD;
        mem_req.addr   = (state_q == S_LINE_REQ)
                       ? {req_buf.tag, req_buf.index, {OFFSET_WIDTH{1'b0}}}
                       : {req_buf.tag, req_buf.index, req_buf.offset};
    end

    assign rdata_valid = lookup_hit || (state_q == S_WORD_DONE && req_buf.valid);
    assign rdata       = (state_q == S_WORD_DONE) ? uncached_q : hit_word;

endmodule

// ==== icache/icache_plru.sv ====
// tree pseudo-lru state for every set, victim lookup and access update
`timescale 1ns/1ps

module icache_plru (
    input  logic              clk,
    input  logic              reset,
    input  logic              update,
    input  cache_pkg::way_t   access_way,
    input  cache_pkg::index_t index,
    input  cache_pkg::index_t victim_index,
    output cache_pkg::way_t   victim
);

    import cache_pkg::*;

    // each bit points at the half to replace next
    typedef struct packed {
        logic root;  // 0 ways 0/1, 1 ways 2/3
        logic left;  // 0 way 0, 1 way 1
        logic right; // 0 way 2, 1 way 3
    } plru_node_t;

    plru_node_t tree_q [SETS];
    plru_node_t node;

    assign node   = tree_q[victim_index];
    assign victim = node.root ? {1'b1, node.right} : {1'b0, node.left};

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int s = 0; s < SETS; s++) begin
                tree_q[s] <= '0;
            end
        end else if (update) begin
            // point the tree away from the way just used
            if (access_way[1]) begin
                tree_q[index].root  <= 1'b0;
                tree_q[index].right <= ~access_way[0];
            end else begin
                tree_q[index].root <= 1'b1;
                tree_q[index].left <= ~access_way[0];
            end
        end
    end

endmodule

// ==== icache/icache_ram.sv ====
// synchronous single-port array with a typed entry, cleared on reset
`timescale 1ns/1ps

module icache_ram #(
    parameter type entry_t = logic [31:0],
    parameter int  DEPTH   = 64
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     we,
    input  logic [$clog2(DEPTH)-1:0] addr,
    input  entry_t                   wdata,
    output entry_t                   rdata
);

    entry_t mem [DEPTH];

    // read-before-write, same address gives the old entry
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= '0; // tag entries come up invalid
            end
            rdata <= '0;
        end else begin
            if (we) begin
                mem[addr] <= wdata;
            end
            rdata <= mem[addr];
        end
    end

endmodule

// ==== icache/icache_top.sv ====
// icache top level: lookup and miss stages, per-way tag and data rams, plru
`timescale 1ns/1ps

module icache_top (
    input  logic                   clk,
    input  logic                   reset,
    input  cache_pkg::cpu_req_t    cpu_req,
    input  logic                   stall,
    input  logic                   flush,
    input  mem_bus_pkg::mem_resp_t mem_resp,
    output logic                   busy,
    output logic                   rdata_valid,
    output cache_pkg::word_t       rdata,
    output mem_bus_pkg::mem_req_t  mem_req
);

    import cache_pkg::*;

    req_buf_t               req_buf;
    index_t                 ram_index;
    logic                   hold;
    logic                   replay;
    index_t                 replay_index;
    tagv_t [WAYS-1:0]       tagv_rdata;
    line_t [WAYS-1:0]       line_rdata;
    way_mask_t              tag_we;
    way_mask_t              data_we;
    tagv_t                  tagv_wdata;
    line_t                  line_wdata;
    logic                   plru_update;
    way_t                   plru_way;
    index_t                 plru_index;
    way_t                   victim;

    icache_lookup u_lookup (
        .clk          (clk),
        .reset        (reset),
        .cpu_req      (cpu_req),
        .stall        (stall),
        .flush        (flush),
        .hold         (hold),
        .replay       (replay),
        .replay_index (replay_index),
        .busy         (busy),
        .req_buf      (req_buf),
        .ram_index    (ram_index),
        .ram_read_en  ()
    );

    icache_miss_ctrl u_miss_ctrl (
        .clk          (clk),
        .reset        (reset),
        .req_buf      (req_buf),
        .tagv_rdata   (tagv_rdata),
        .line_rdata   (line_rdata),
        .victim       (victim),
        .stall        (stall),
        .mem_resp     (mem_resp),
        .hold         (hold),
        .replay       (replay),
        .replay_index (replay_index),
        .tag_we       (tag_we),
        .data_we      (data_we),
        .tagv_wdata   (tagv_wdata),
        .line_wdata   (line_wdata),
        .plru_update  (plru_update),
        .plru_way     (plru_way),
        .plru_index   (plru_index),
        .mem_req      (mem_req),
        .rdata_valid  (rdata_valid),
        .rdata        (rdata)
    );

    icache_plru u_plru (
        .clk          (clk),
        .reset        (reset),
        .update       (plru_update),
        .access_way   (plru_way),
        .index        (plru_index),
        .victim_index (plru_index), // victim always for the buffered set
        .victim       (victim)
    );

    for (genvar w = 0; w < WAYS; w++) begin : g_way
        icache_ram #(
            .entry_t (tagv_t),
            .DEPTH   (SETS)
        ) u_tag_ram (
            .clk   (clk),
            .reset (reset),
            .we    (tag_we[w]),
            .addr  (ram_index),
            .wdata (tagv_wdata),
            .rdata (tagv_rdata[w])
        );

        icache_ram #(
            .entry_t (line_t),
            .DEPTH   (SETS)
        ) u_data_ram (
            .clk   (clk),
            .reset (reset),
            .we    (data_we[w]),
            .addr  (ram_index),
            .wdata (line_wdata),
            .rdata (line_rdata[w])
        );
    end

endmodule

// ==== project.f ====
common/cache_pkg.sv
common/mem_bus_pkg.sv
icache/icache_ram.sv
icache/icache_plru.sv
icache/icache_lookup.sv
icache/icache_miss_ctrl.sv
icache/icache_top.sv
testbench/tb_mem_model.sv
testbench/tb_icache.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the icache testbench with verilator, run it, and look for the pass line in the log
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=sim_icache

if ! verilator --binary --timing --assert --top-module tb_icache -f project.f -o "$BIN"; then
    echo "verilator compile failed"
    exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if ! grep -q "^TB PASSED$" "$LOG"; then
    echo "pass line not found in $LOG"
    exit 1
fi

exit 0

// ==== testbench/icache_input.txt ====
// columns: op addr cached expected_word line_fetches_so_far
// op 0 read, 1 read under stall, 2 flushed read then read, f end of vectors
// cold line in set 1, then the other three words of it
0 00001010 1 12344668 1
0 00001014 1 1234466c 1
0 00001018 1 12344660 1
0 0000101c 1 12344664 1
// uncached twice, then the same address cached
0 00002020 0 12347658 1
0 00002020 0 12347658 1
0 00002020 1 12347658 2
// set 3 filled with tags A B C D, then E evicts A
0 00010030 1 12355648 3
0 00020030 1 12365648 4
0 00030030 1 12375648 5
0 00040030 1 12305648 6
0 00050030 1 12315648 7
// B still present, A fetched again
0 00020030 1 12365648 7
0 00010030 1 12355648 8
// stall over a hit and over an uncached return
1 00001014 1 1234466c 8
1 00002024 0 1234765c 8
// flushed request, then served
2 00003040 1 12346638 9
0 00003044 1 1234663c 9
f 00000000 0 00000000 0

// ==== testbench/tb_icache.sv ====
// icache testbench with clock and reset, file-driven cpu reads, response and fetch checks
`timescale 1ns/1ps

module tb_icache;

    import cache_pkg::*;
    import mem_bus_pkg::*;

    localparam int CLK_PERIOD   = 40;
    localparam int DRIVE_DELAY  = 1;
    localparam int TIMEOUT      = 100; // cycles allowed per wait
    localparam int MAX_VECS     = 64;
    localparam int VEC_FIELDS   = 5;
    localparam int STALL_CYCLES = 4;

    localparam logic [3:0] OP_STALL = 4'h1;
    localparam logic [3:0] OP_FLUSH = 4'h2;
    localparam logic [3:0] OP_END   = 4'hf;

    logic        clk;
    logic        reset;
    cpu_req_t    cpu_req;
    logic        stall;
    logic        flush;
    logic        busy;
    logic        rdata_valid;
    word_t       rdata;
    mem_req_t    mem_req;
    mem_resp_t   mem_resp;
    int          line_fetches;
    int          word_fetches;

    logic [31:0] vec_mem [MAX_VECS*VEC_FIELDS];
    int          data_errors;
    int          timeout_errors;
    int          expected_words;
    int          last_lines;

    icache_top UUT (
        .clk         (clk),
        .reset       (reset),
        .cpu_req     (cpu_req),
        .stall       (stall),
        .flush       (flush),
        .mem_resp    (mem_resp),
        .busy        (busy),
        .rdata_valid (rdata_valid),
        .rdata       (rdata),
        .mem_req     (mem_req)
    );

    tb_mem_model u_mem (
        .clk          (clk),
        .reset        (reset),
        .mem_req      (mem_req),
        .mem_resp     (mem_resp),
        .line_fetches (line_fetches),
        .word_fetches (word_fetches)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic check_bit(input string name, input logic got, input logic exp);
        assert (got === exp) else begin
            $display("** Error %s: got %h, expected %h", name, got, exp);
            data_errors++;
        end
    endtask

    task automatic check_word(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        assert (got === exp) else begin
            $display("** Error %s: got %h, expected %h", name, got, exp);
            data_errors++;
        end
    endtask

    // returns 1 ns after the edge that accepted the request
    task automatic present_request(input addr_t addr, input logic cached, output bit accepted);
        int cycles;
        cycles   = 0;
        accepted = 1'b0;
        cpu_req.valid  = 1'b1;
        cpu_req.addr   = addr;
        cpu_req.cached = cached;
        while (!accepted && cycles < TIMEOUT) begin
            @(negedge clk);
            accepted = !busy && !stall;
            @(posedge clk);
            #DRIVE_DELAY;
            cycles++;
        end
        cpu_req.valid = 1'b0;
        if (!accepted) begin
            $display("timeout: request for address %h was never accepted", addr);
            timeout_errors++;
        end
    endtask

    // busy is checked in the first cycle after acceptance
    task automatic wait_response(input bit expect_busy, output int latency,
                                 output bit answered);
        latency  = 0;
        answered = 1'b0;
        while (!answered && latency < TIMEOUT) begin
            @(negedge clk);
            latency++;
            if (latency == 1) begin
                check_bit("busy", busy, expect_busy);
            end
            answered = rdata_valid;
        end
        if (!answered) begin
            $display("timeout: no rdata_valid within %0d cycles of acceptance", TIMEOUT);
            timeout_errors++;
        end
    endtask

    task automatic check_response(input word_t exp_data, input int exp_lines);
        check_word("rdata", rdata, exp_data);
        check_word("line_fetches", line_fetches, exp_lines);
        check_word("word_fetches", word_fetches, expected_words);
    endtask

    // held response under stall while a neighbour request waits untaken
    task automatic stall_over_response(input addr_t addr, input logic cached);
        word_t held;
        held = rdata;
        @(posedge clk);
        #DRIVE_DELAY;
        cpu_req.valid  = 1'b1;
        cpu_req.addr   = addr ^ 32'h4;
        cpu_req.cached = cached;
        repeat (STALL_CYCLES) begin
            @(negedge clk);
            check_bit("rdata_valid", rdata_valid, 1'b1);
            check_word("rdata", rdata, held);
        end
        @(posedge clk);
        #DRIVE_DELAY;
        stall         = 1'b0;
        cpu_req.valid = 1'b0;
        @(posedge clk); // held response consumed here
        @(negedge clk);
        check_bit("rdata_valid", rdata_valid, 1'b0);
    endtask

    task automatic flush_request(input addr_t addr, input logic cached);
        bit accepted;
        present_request(addr, cached, accepted);
        flush = 1'b1;
        @(negedge clk);
        check_bit("rdata_valid", rdata_valid, 1'b0);
        check_bit("busy", busy, 1'b0);
        @(posedge clk);
        #DRIVE_DELAY;
        flush = 1'b0;
        repeat (3) begin
            @(negedge clk);
            check_bit("rdata_valid", rdata_valid, 1'b0);
            check_bit("busy", busy, 1'b0);
        end
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    task automatic run_vector(input logic [3:0] op, input addr_t addr, input logic cached,
                              input word_t exp_data, input int exp_lines);
        bit accepted;
        bit answered;
        bit expect_busy;
        int latency;
        if (op == OP_FLUSH) begin
            flush_request(addr, cached);
        end
        present_request(addr, cached, accepted);
        if (accepted) begin
            if (!cached) begin
                expected_words++;
            end
            // uncached reads and line fetches raise busy, hits do not
            expect_busy = !cached || exp_lines != last_lines;
            stall = (op == OP_STALL); // up before the response cycle
            wait_response(expect_busy, latency, answered);
            if (answered) begin
                check_response(exp_data, exp_lines);
                // a hit is answered one cycle after acceptance
                if (!expect_busy) begin
                    check_word("hit latency", latency, 1);
                end
                if (op == OP_STALL) begin
                    stall_over_response(addr, cached);
                end
            end
            @(posedge clk);
            #DRIVE_DELAY;
            stall = 1'b0;
        end
        last_lines = exp_lines;
    endtask

    initial begin
        logic [3:0] op;
        int         base;

        void'($urandom(32'h8ff0_56c0));
        clk            = 1'b0;
        reset          = 1'b1;
        cpu_req        = '0;
        stall          = 1'b0;
        flush          = 1'b0;
        data_errors    = 0;
        timeout_errors = 0;
        expected_words = 0;
        last_lines     = 0;
        $readmemh("testbench/icache_input.txt", vec_mem);

        repeat (3) @(posedge clk);
        #DRIVE_DELAY;
        reset = 1'b0;
        @(negedge clk);
        check_bit("busy", busy, 1'b0);
        check_bit("rdata_valid", rdata_valid, 1'b0);
        check_bit("mem_req.rd_req", mem_req.rd_req, 1'b0);
        @(posedge clk);
        #DRIVE_DELAY;

        for (int v = 0; v < MAX_VECS; v++) begin
            base = v * VEC_FIELDS;
            op   = vec_mem[base][3:0];
            if (op == OP_END) begin
                break;
            end
            run_vector(op, vec_mem[base+1], vec_mem[base+2][0], vec_mem[base+3],
                       int'(vec_mem[base+4]));
        end

        $display("errors: %0d wrong values, %0d timeouts", data_errors, timeout_errors);
        if (data_errors == 0 && timeout_errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// ==== testbench/tb_mem_model.sv ====
// memory responder with address xor pattern, random ready delay and line and word fetch counters
`timescale 1ns/1ps

module tb_mem_model (
    input  logic                   clk,
    input  logic                   reset,
    input  mem_bus_pkg::mem_req_t  mem_req,
    output mem_bus_pkg::mem_resp_t mem_resp,
    output int                     line_fetches,
    output int                     word_fetches
);

    import cache_pkg::*;
    import mem_bus_pkg::*;

    localparam logic [31:0] PATTERN = 32'h1234_5678;

    typedef enum logic [1:0] {
        M_IDLE,
        M_DELAY,
        M_READY, // address moves at this edge
        M_BEATS
    } mstate_t;

    mstate_t     state;
    int          delay;
    int          beat;
    int          beats;
    logic [31:0] base;

    function automatic logic [31:0] pattern_word(input logic [31:0] addr);
        return {addr[31:2], 2'b00} ^ PATTERN;
    endfunction

    always @(posedge clk) begin
        if (reset) begin
            state        <= M_IDLE;
            mem_resp     <= '0;
            line_fetches <= 0;
            word_fetches <= 0;
            delay        <= 0;
            beat         <= 0;
            beats        <= 0;
            base         <= '0;
        end else begin
            mem_resp.ret_valid <= 1'b0;
            mem_resp.ret_last  <= 1'b0;
            case (state)
                M_IDLE: begin
                    if (mem_req.rd_req) begin
                        delay <= int'($urandom % 4);
                        state <= M_DELAY;
                    end
                end
                M_DELAY: begin
                    if (delay == 0) begin
                        mem_resp.rd_rdy <= 1'b1;
                        state           <= M_READY;
                    end else begin
                        delay <= delay - 1;
                    end
                end
                M_READY: begin
                    mem_resp.rd_rdy <= 1'b0;
                    base            <= mem_req.addr;
                    beat            <= 0;
                    if (mem_req.burst == BURST_LINE) begin
                        beats        <= LINE_WORDS;
                        line_fetches <= line_fetches + 1;
                    end else begin
                        beats        <= 1;
                        word_fetches <= word_fetches + 1;
                    end
                    state <= M_BEATS;
                end
                default: begin
                    // beat k carries word k
                    mem_resp.ret_valid <= 1'b1;
                    mem_resp.ret_data  <= pattern_word(base + 32'(beat * 4));
                    mem_resp.ret_last  <= beat == beats - 1;
                    beat               <= beat + 1;
                    if (beat == beats - 1) begin
                        state <= M_IDLE;
                    end
                end
            endcase
        end
    end

endmodule
